//--- verilog/adder_pkg.sv
// Bus word is 32 bits and result flags are placed relative to WIDTH, so WIDTH must stay within 28
package adder_pkg;

	// One Wishbone data word, used in both directions
	typedef logic [31:0] wb_data_t;

	// Word address into the four register slots
	typedef logic [1:0] reg_addr_t;

	// Register map
	localparam reg_addr_t ADDR_OPA    = 2'd0;
	localparam reg_addr_t ADDR_OPB    = 2'd1;
	localparam reg_addr_t ADDR_CTRL   = 2'd2;
	localparam reg_addr_t ADDR_RESULT = 2'd3;

	// Flag positions in the result word
	// Carry-out and overflow are offsets above the sum field
	localparam int RES_COUT_BIT  = 0;
	localparam int RES_OVF_BIT   = 1;
	// Valid is fixed at the top of the word
	localparam int RES_VALID_BIT = 31;

endpackage

//--- verilog/ling_prefix_adder.sv
// Purely combinational and unpipelined; WIDTH must be even and at least 4
module ling_prefix_adder #(
	parameter int WIDTH = 18
) (
	input  logic [WIDTH-1:0] op_a,
	input  logic [WIDTH-1:0] op_b,
	input  logic             cin,
	output logic [WIDTH-1:0] sum,
	output logic             cout,
	output logic             carry_msb
);

	// Tree works on bit pairs, one pseudo-carry per odd position
	localparam int NP = WIDTH / 2;
	localparam int LV = $clog2(NP);
	// Span of the last combining step
	localparam int SF = 1 << (LV - 1);

	// Position 0 carries cin, position k+1 holds operand bit k
	logic [WIDTH:0]   p;
	logic [WIDTH:0]   g;
	// Ling pseudo-carries H(k:0) for odd pairs after the tree
	logic [NP-1:0]    hh;
	logic [WIDTH-1:1] h;
	logic             h_top;
	// Real carry into each position
	logic [WIDTH:1]   c;

	// Pre-computation
	assign p = {op_a | op_b, 1'b1};
	assign g = {op_a & op_b, cin};

	genvar l, m, k;
	generate
		// Each level keeps its own H/I vectors
		for (l = 0; l < LV; l++) begin : g_lvl
			localparam int S = (1 << l) >> 1;
			logic [NP-1:0] hv;
			logic [NP-1:0] iv;

			for (m = 0; m < NP; m++) begin : g_pair
				if (l == 0) begin : g_reduced
					if (m == 0) begin : g_rgry
						// p[0] is tied high, so only generates matter here
						assign hv[m] = g[1] | g[0];
						assign iv[m] = p[0];
					end else begin : g_rblk
						assign hv[m] = g[2*m+1] | g[2*m];
						assign iv[m] = p[2*m] & p[2*m-1];
					end
				end else if (m < S) begin : g_pass
					// Already reaches position 0
					assign hv[m] = g_lvl[l-1].hv[m];
					assign iv[m] = g_lvl[l-1].iv[m];
				end else if (m < 2 * S) begin : g_grey
					assign hv[m] = g_lvl[l-1].hv[m] |
						(g_lvl[l-1].iv[m] & g_lvl[l-1].hv[m-S]);
					assign iv[m] = g_lvl[l-1].iv[m];
				end else begin : g_black
					assign hv[m] = g_lvl[l-1].hv[m] |
						(g_lvl[l-1].iv[m] & g_lvl[l-1].hv[m-S]);
					assign iv[m] = g_lvl[l-1].iv[m] & g_lvl[l-1].iv[m-S];
				end
			end
		end

		// Last step closes every remaining group onto position 0
		for (m = 0; m < NP; m++) begin : g_final
			if (m < SF) begin : g_pass
				assign hh[m] = g_lvl[LV-1].hv[m];
			end else begin : g_grey
				assign hh[m] = g_lvl[LV-1].hv[m] |
					(g_lvl[LV-1].iv[m] & g_lvl[LV-1].hv[m-SF]);
			end
		end

		for (m = 0; m < NP; m++) begin : g_odd
			assign h[2*m+1] = hh[m];
		end

		// Extra grey stage for the even positions
		for (k = 1; k < NP; k++) begin : g_even
			assign h[2*k] = g[2*k] | (p[2*k-1] & hh[k-1]);
		end

		// c(k+1) = p(k) & H(k:0)
		for (k = 1; k < WIDTH; k++) begin : g_carry
			assign c[k+1] = p[k] & h[k];
		end
	endgenerate

	assign c[1] = g[0];

	// Top position has no tree entry, rebuilt from its carry
	assign h_top = g[WIDTH] | c[WIDTH];

	// Post-computation
	assign sum       = (p[WIDTH:1] ^ {h_top, h}) | (g[WIDTH:1] & c);
	assign cout      = p[WIDTH] & h_top;
	assign carry_msb = c[WIDTH];

endmodule

//--- verilog/wb_operand_regs.sv
// Wishbone classic slave, zero wait states, ignores sel and never signals err or retry
module wb_operand_regs import adder_pkg::*; #(
	parameter int WIDTH = 18
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             cyc,
	input  logic             stb,
	input  logic             we,
	input  reg_addr_t        adr,
	input  wb_data_t         dat_i,
	output wb_data_t         dat_o,
	output logic             ack,
	output logic [WIDTH-1:0] op_a,
	output logic [WIDTH-1:0] op_b,
	output logic             cin,
	output logic             start,
	output logic             clear,
	input  wb_data_t         result
);

	logic     req;
	logic     wr_en;
	logic     sel_opa;
	logic     sel_opb;
	logic     sel_ctrl;
	logic     wr_ctrl_q;
	logic     wr_op_q;
	wb_data_t rd_data;

	// A held strobe is not taken again while ack is high
	assign req   = cyc & stb & ~ack;
	assign wr_en = req & we;

	// Address decode, shared by writes and reads
	assign sel_opa  = (adr == ADDR_OPA);
	assign sel_opb  = (adr == ADDR_OPB);
	assign sel_ctrl = (adr == ADDR_CTRL);

	always_comb begin
		rd_data = '0;
		if (sel_opa) begin
			rd_data[WIDTH-1:0] = op_a;
		end else if (sel_opb) begin
			rd_data[WIDTH-1:0] = op_b;
		end else if (sel_ctrl) begin
			rd_data[0] = cin;
		end else begin
			rd_data = result;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			ack       <= 1'b0;
			dat_o     <= '0;
			op_a      <= '0;
			op_b      <= '0;
			cin       <= 1'b0;
			wr_ctrl_q <= 1'b0;
			wr_op_q   <= 1'b0;
			start     <= 1'b0;
			clear     <= 1'b0;
		end else begin
			ack       <= req;
			// Flags live during the ack cycle, pulses follow one cycle later
			wr_ctrl_q <= wr_en & sel_ctrl;
			wr_op_q   <= wr_en & (sel_opa | sel_opb);
			start     <= wr_ctrl_q;
			clear     <= wr_op_q;
			// Read data sampled together with ack
			if (req) begin
				dat_o <= rd_data;
			end
			if (wr_en && sel_opa) begin
				op_a <= dat_i[WIDTH-1:0];
			end
			if (wr_en && sel_opb) begin
				op_b <= dat_i[WIDTH-1:0];
			end
			if (wr_en && sel_ctrl) begin
				cin <= dat_i[0];
			end
		end
	end

endmodule

//--- verilog/sum_capture.sv
// Result word layout assumes WIDTH+1 stays below the valid bit at 31
module sum_capture import adder_pkg::*; #(
	parameter int WIDTH = 18
) (
	input  logic             clk,
	input  logic             reset,
	input  logic             start,
	input  logic             clear,
	input  logic [WIDTH-1:0] sum,
	input  logic             cout,
	input  logic             carry_msb,
	output wb_data_t         result
);

	logic [WIDTH-1:0] sum_q;
	logic             cout_q;
	logic             ovf_q;
	logic             valid_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			sum_q   <= '0;
			cout_q  <= 1'b0;
			ovf_q   <= 1'b0;
			valid_q <= 1'b0;
		end else if (start) begin
			sum_q   <= sum;
			cout_q  <= cout;
			// Signed overflow when carries into and out of the MSB differ
			ovf_q   <= carry_msb ^ cout;
			valid_q <= 1'b1;
		end else if (clear) begin
			// Old fields stay readable
			valid_q <= 1'b0;
		end
	end

	always_comb begin
		result                             = '0;
		result[WIDTH-1:0]                  = sum_q;
		result[WIDTH + RES_COUT_BIT]       = cout_q;
		result[WIDTH + RES_OVF_BIT]        = ovf_q;
		result[RES_VALID_BIT]              = valid_q;
	end

endmodule

//--- verilog/adder_top.sv
// WIDTH must be even and between 4 and 28; no interrupts, sel is not a port
module adder_top import adder_pkg::*; #(
	parameter int WIDTH = 18
) (
	input  logic      clk,
	input  logic      reset,
	input  logic      cyc,
	input  logic      stb,
	input  logic      we,
	input  reg_addr_t adr,
	input  wb_data_t  dat_i,
	output wb_data_t  dat_o,
	output logic      ack
);

	logic [WIDTH-1:0] op_a;
	logic [WIDTH-1:0] op_b;
	logic             cin;
	logic             start;
	logic             clear;
	logic [WIDTH-1:0] sum;
	logic             cout;
	logic             carry_msb;
	wb_data_t         result;

	// Input side
	wb_operand_regs #(.WIDTH(WIDTH)) u_regs (
		.clk(clk), .reset(reset),
		.cyc(cyc), .stb(stb), .we(we), .adr(adr), .dat_i(dat_i),
		.dat_o(dat_o), .ack(ack),
		.op_a(op_a), .op_b(op_b), .cin(cin),
		.start(start), .clear(clear),
		.result(result)
	);

	// Processing
	ling_prefix_adder #(.WIDTH(WIDTH)) u_adder (
		.op_a(op_a), .op_b(op_b), .cin(cin),
		.sum(sum), .cout(cout), .carry_msb(carry_msb)
	);

	// Output side
	sum_capture #(.WIDTH(WIDTH)) u_capture (
		.clk(clk), .reset(reset),
		.start(start), .clear(clear),
		.sum(sum), .cout(cout), .carry_msb(carry_msb),
		.result(result)
	);

endmodule

//--- dv/adder_sva.sv
// Checks the bus handshake and the valid bit only; flags use the package layout with WIDTH <= 28
module adder_sva (
	input logic clk,
	input logic reset,
	input logic cyc,
	input logic stb,
	input logic ack,
	input logic start,
	input logic valid
);
	timeunit 1ns;
	timeprecision 1ps;

	// Zero wait states, so ack answers the request of the previous cycle
	ack_follows_req: assert property (@(posedge clk) disable iff (reset)
		ack |-> $past(cyc && stb))
		else $error("ack raised without a preceding cyc and stb");

	ack_single: assert property (@(posedge clk) disable iff (reset)
		ack |=> !ack)
		else $error("ack held high for two cycles");

	ack_after_reset: assert property (@(posedge clk) reset |=> !ack)
		else $error("ack high in the cycle after reset");

	valid_after_start: assert property (@(posedge clk) disable iff (reset)
		$rose(valid) |-> $past(start))
		else $error("valid rose without a start in the previous cycle");

endmodule

bind wb_operand_regs adder_sva u_sva_regs (
	.clk(clk), .reset(reset), .cyc(cyc), .stb(stb), .ack(ack),
	.start(start), .valid(result[adder_pkg::RES_VALID_BIT])
);

// No bus here, only the capture side of valid
bind sum_capture adder_sva u_sva_capture (
	.clk(clk), .reset(reset), .cyc(1'b0), .stb(1'b0), .ack(1'b0),
	.start(start), .valid(result[adder_pkg::RES_VALID_BIT])
);

//--- dv/adder_tb.sv
// Runs at WIDTH 18 with a zero-wait-state bus; every ack and valid poll gives up after 20 cycles
module adder_tb import adder_pkg::*;;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int WIDTH    = 18;
	localparam int TIMEOUT  = 20;
	localparam int N_RANDOM = 200;

	logic      clk = 1'b0;
	logic      reset;
	logic      cyc;
	logic      stb;
	logic      we;
	reg_addr_t adr;
	wb_data_t  dat_i;
	wb_data_t  dat_o;
	logic      ack;

	logic [31:0] lfsr_state;
	int          cycle_cnt = 0;
	int          mismatch_count = 0;
	int          timeout_count = 0;
	int          check_count = 0;
	int          tests_passed = 0;
	int          tests_failed = 0;
	int          test_start_errs;
	string       cur_test;

	// Reads waiting for the compare process
	wb_data_t exp_q[$];
	wb_data_t act_q[$];
	string    name_q[$];
	wb_data_t c_exp;
	wb_data_t c_act;
	string    c_name;

	adder_top #(.WIDTH(WIDTH)) uut (
		.clk(clk), .reset(reset), .cyc(cyc), .stb(stb), .we(we),
		.adr(adr), .dat_i(dat_i), .dat_o(dat_o), .ack(ack)
	);

	always #4 clk = ~clk;

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	// Compare process, away from the drive edge
	always @(negedge clk) begin
		while (act_q.size() > 0) begin
			c_exp  = exp_q.pop_front();
			c_act  = act_q.pop_front();
			c_name = name_q.pop_front();
			if (c_act !== c_exp) begin
				$display("error %s: expected 0x%08h actual 0x%08h", c_name, c_exp, c_act);
				mismatch_count++;
			end
		end
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		int          i;
		v = '0;
		for (i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
		return v;
	endfunction

	function automatic logic [WIDTH-1:0] random_operand();
		logic [31:0] v;
		v = random_bits(WIDTH);
		return v[WIDTH-1:0];
	endfunction

	function automatic logic random_bit();
		logic [31:0] v;
		v = random_bits(1);
		return v[0];
	endfunction

	function automatic wb_data_t zext(input logic [WIDTH-1:0] v);
		return {{(32 - WIDTH){1'b0}}, v};
	endfunction

	// Expected result word for a + b + cin
	function automatic wb_data_t ref_result(input logic [WIDTH-1:0] a,
		input logic [WIDTH-1:0] b, input logic c);
		logic [WIDTH:0]   full;
		logic [WIDTH-1:0] s;
		logic             ovf;
		wb_data_t         r;
		full = {1'b0, a} + {1'b0, b} + {{WIDTH{1'b0}}, c};
		s    = full[WIDTH-1:0];
		// Same operand signs, different sum sign
		ovf  = (a[WIDTH-1] == b[WIDTH-1]) && (s[WIDTH-1] != a[WIDTH-1]);
		r    = '0;
		r[WIDTH-1:0]               = s;
		r[WIDTH + RES_COUT_BIT]    = full[WIDTH];
		r[WIDTH + RES_OVF_BIT]     = ovf;
		r[RES_VALID_BIT]           = 1'b1;
		return r;
	endfunction

	task automatic bus_cycle(input logic write, input reg_addr_t a, input wb_data_t d,
		output wb_data_t rd);
		int   waited;
		logic got;
		waited = 0;
		got    = 1'b0;
		rd     = '0;
		@(posedge clk);
		#1;
		cyc   = 1'b1;
		stb   = 1'b1;
		we    = write;
		adr   = a;
		dat_i = d;
		while (!got && waited < TIMEOUT) begin
			@(posedge clk);
			#1;
			waited++;
			if (ack) begin
				got = 1'b1;
				rd  = dat_o;
			end
		end
		cyc = 1'b0;
		stb = 1'b0;
		we  = 1'b0;
		if (!got) begin
			$display("test %s: no ack from the DUT within %0d cycles at address %0d",
				cur_test, TIMEOUT, a);
			timeout_count++;
		end
	endtask

	task automatic bus_write(input reg_addr_t a, input wb_data_t d);
		wb_data_t unused;
		bus_cycle(1'b1, a, d, unused);
	endtask

	task automatic bus_read(input reg_addr_t a, output wb_data_t rd);
		bus_cycle(1'b0, a, '0, rd);
	endtask

	task automatic check_result(input string name, input wb_data_t exp, input wb_data_t act);
		exp_q.push_back(exp);
		act_q.push_back(act);
		name_q.push_back(name);
		check_count++;
	endtask

	task automatic wait_valid(input logic want, output wb_data_t res);
		int   start_cyc;
		logic seen;
		start_cyc = cycle_cnt;
		seen      = 1'b0;
		res       = '0;
		while (!seen && (cycle_cnt - start_cyc) < TIMEOUT) begin
			bus_read(ADDR_RESULT, res);
			if (res[RES_VALID_BIT] == want) begin
				seen = 1'b1;
			end
		end
		if (!seen) begin
			$display("test %s: valid bit did not become %0d within %0d cycles",
				cur_test, want, TIMEOUT);
			timeout_count++;
		end
	endtask

	task automatic run_add(input string name, input logic [WIDTH-1:0] a,
		input logic [WIDTH-1:0] b, input logic c);
		wb_data_t res;
		bus_write(ADDR_OPA, zext(a));
		bus_write(ADDR_OPB, zext(b));
		bus_write(ADDR_CTRL, {31'b0, c});
		wait_valid(1'b1, res);
		check_result(name, ref_result(a, b, c), res);
	endtask

	task automatic begin_test(input string name);
		cur_test        = name;
		test_start_errs = mismatch_count + timeout_count;
	endtask

	task automatic end_test();
		int waited;
		int errs;
		waited = 0;
		while (act_q.size() > 0 && waited < TIMEOUT) begin
			@(posedge clk);
			waited++;
		end
		if (act_q.size() > 0) begin
			$display("test %s: compare process did not drain its queue", cur_test);
			timeout_count++;
		end
		errs = mismatch_count + timeout_count - test_start_errs;
		if (errs == 0) begin
			tests_passed++;
			$display("test %s passed", cur_test);
		end else begin
			tests_failed++;
			$display("test %s failed with %0d errors", cur_test, errs);
		end
	endtask

	initial begin
		wb_data_t         rd;
		wb_data_t         old_res;
		logic [WIDTH-1:0] a;
		logic [WIDTH-1:0] b;
		logic [WIDTH-1:0] mask;
		logic             c;
		int               i;
		reset      = 1'b1;
		cyc        = 1'b0;
		stb        = 1'b0;
		we         = 1'b0;
		adr        = '0;
		dat_i      = '0;
		lfsr_state = 32'h6397;
		mask       = '1;
		repeat (4) @(posedge clk);
		#1 reset = 1'b0;

		begin_test("reset_values");
		for (i = 0; i < 4; i++) begin
			bus_read(i[1:0], rd);
			check_result($sformatf("reset_values[%0d]", i), '0, rd);
		end
		end_test();

		begin_test("readback");
		bus_write(ADDR_OPA, 32'hDEAD_BEEF);
		bus_read(ADDR_OPA, rd);
		check_result("readback_opa", 32'hDEAD_BEEF & zext(mask), rd);
		bus_write(ADDR_OPB, 32'h1234_5678);
		bus_read(ADDR_OPB, rd);
		check_result("readback_opb", 32'h1234_5678 & zext(mask), rd);
		bus_write(ADDR_CTRL, 32'hFFFF_FFFF);
		bus_read(ADDR_CTRL, rd);
		check_result("readback_ctrl_one", 32'h1, rd);
		bus_write(ADDR_CTRL, 32'h0000_0002);
		bus_read(ADDR_CTRL, rd);
		check_result("readback_ctrl_zero", 32'h0, rd);
		end_test();

		begin_test("corners");
		run_add("zero_plus_zero", '0, '0, 1'b0);
		run_add("ones_plus_cin", mask, '0, 1'b1);
		run_add("max_pos_plus_one", mask >> 1, 1, 1'b0);
		run_add("min_neg_plus_ones", ~(mask >> 1), mask, 1'b0);
		end_test();

		begin_test("random");
		for (i = 0; i < N_RANDOM; i++) begin
			a = random_operand();
			b = random_operand();
			c = random_bit();
			run_add($sformatf("random[%0d]", i), a, b, c);
		end
		end_test();

		begin_test("clear_valid");
		a = random_operand();
		b = random_operand();
		run_add("clear_first_add", a, b, 1'b1);
		old_res = ref_result(a, b, 1'b1);
		old_res[RES_VALID_BIT] = 1'b0;
		a = random_operand();
		bus_write(ADDR_OPA, zext(a));
		// Fields of the old sum stay visible once valid drops
		wait_valid(1'b0, rd);
		check_result("clear_after_opa", old_res, rd);
		bus_write(ADDR_CTRL, 32'h0);
		wait_valid(1'b1, rd);
		check_result("clear_second_add", ref_result(a, b, 1'b0), rd);
		end_test();

		$display("%0d tests passed, %0d failed, %0d checks, %0d mismatches, %0d timeouts",
			tests_passed, tests_failed, check_count, mismatch_count, timeout_count);
		if (tests_failed == 0 && mismatch_count == 0 && timeout_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

//--- all.f
verilog/adder_pkg.sv
verilog/ling_prefix_adder.sv
verilog/wb_operand_regs.sv
verilog/sum_capture.sv
verilog/adder_top.sv
dv/adder_sva.sv
dv/adder_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := adder_tb
FILELIST  := all.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := Regression passed

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status comes from the search for the pass line
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
